// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_core
FLIST     = flist.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+include
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/alu.sv
src/branch_cmp.sv
src/controller.sv
src/datapath.sv
src/rv_core.sv
tb/core_asserts.sv
tb/core_checker.sv
tb/tb_core.sv

// ==== include/rv_config.svh ====
/* core sizing for an RV32I build
   RV_XLEN must stay 32 since the immediate formats are fixed to RV32 */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, gives the 5 bit index
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== src/alu.sv ====
/* RV32I integer alu, combinational
   shift amount is b[4:0], comparisons give 0 or 1 */
`include "rv_config.svh"

module alu (
	input  logic [`RV_XLEN-1:0]  a,
	input  logic [`RV_XLEN-1:0]  b,
	input  rv_ctrl_pkg::alu_op_e op,
	output logic [`RV_XLEN-1:0]  y
);
	localparam int shamt_w = $clog2(`RV_XLEN);

	logic [shamt_w-1:0] shamt;
	logic               lt_s, lt_u;

	assign shamt = b[shamt_w-1:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			rv_ctrl_pkg::alu_add:  y = a + b;
			rv_ctrl_pkg::alu_sub:  y = a - b;
			rv_ctrl_pkg::alu_sll:  y = a << shamt;
			rv_ctrl_pkg::alu_slt:  y = {{(`RV_XLEN-1){1'b0}}, lt_s};
			rv_ctrl_pkg::alu_sltu: y = {{(`RV_XLEN-1){1'b0}}, lt_u};
			rv_ctrl_pkg::alu_xor:  y = a ^ b;
			rv_ctrl_pkg::alu_srl:  y = a >> shamt;
			rv_ctrl_pkg::alu_sra:  y = $unsigned($signed(a) >>> shamt); // keeps sign
			rv_ctrl_pkg::alu_or:   y = a | b;
			rv_ctrl_pkg::alu_and:  y = a & b;
			default:               y = a + b;
		endcase
	end

endmodule : alu

// ==== src/branch_cmp.sv ====
/* branch condition evaluation on rs1 / rs2
   taken is raw, the controller qualifies it with the branch opcode */
`include "rv_config.svh"

module branch_cmp (
	input  logic [`RV_XLEN-1:0]     a,
	input  logic [`RV_XLEN-1:0]     b,
	input  rv_isa_pkg::br_funct_e   funct3,
	output logic                    taken
);
	logic eq, lt_s, lt_u;

	assign eq   = (a == b);
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (funct3)
			rv_isa_pkg::br_beq:  taken = eq;
			rv_isa_pkg::br_bne:  taken = !eq;
			rv_isa_pkg::br_blt:  taken = lt_s;
			rv_isa_pkg::br_bge:  taken = !lt_s;
			rv_isa_pkg::br_bltu: taken = lt_u;
			rv_isa_pkg::br_bgeu: taken = !lt_u;
			default:             taken = 1'b0; // funct3 2 and 3 are reserved
		endcase
	end

endmodule : branch_cmp

// ==== src/controller.sv ====
/* single-cycle RV32I main decoder, purely combinational
   unknown opcodes and fence/system give a no-op; writes held off while reset is low */
module controller (
	input  logic                  reset,
	input  logic [31:0]           instr,
	input  logic                  br_taken,
	output rv_ctrl_pkg::alu_op_e  alu_op,
	output logic                  alu_src_imm,
	output rv_ctrl_pkg::wb_sel_e  wb_sel,
	output logic                  reg_write,
	output logic                  mem_write,
	output rv_ctrl_pkg::pc_sel_e  pc_sel
);
	rv_isa_pkg::opcode_e  opcode;
	logic [2:0]           funct3;
	logic                 funct7_b5;
	logic                 alt_en;    // funct7[5] selects sub / sra
	rv_ctrl_pkg::alu_op_e arith_op;
	logic                 reg_write_d, mem_write_d;
	logic                 branch;
	rv_ctrl_pkg::pc_sel_e pc_kind;   // pc source before branch resolve

	assign opcode    = rv_isa_pkg::opcode_e'(instr[6:0]);
	assign funct3    = instr[14:12];
	assign funct7_b5 = instr[30];

	// reg-reg always, reg-imm only for the shifts (imm[10] of srai)
	assign alt_en = (opcode == rv_isa_pkg::opc_op) ||
		((opcode == rv_isa_pkg::opc_op_imm) && (funct3 == 3'b101));

	always_comb begin
		case (funct3)
			3'b000:  arith_op = (alt_en && funct7_b5) ? rv_ctrl_pkg::alu_sub : rv_ctrl_pkg::alu_add;
			3'b001:  arith_op = rv_ctrl_pkg::alu_sll;
			3'b010:  arith_op = rv_ctrl_pkg::alu_slt;
			3'b011:  arith_op = rv_ctrl_pkg::alu_sltu;
			3'b100:  arith_op = rv_ctrl_pkg::alu_xor;
			3'b101:  arith_op = (alt_en && funct7_b5) ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
			3'b110:  arith_op = rv_ctrl_pkg::alu_or;
			default: arith_op = rv_ctrl_pkg::alu_and;
		endcase
	end

	always_comb begin
		// no-op unless an opcode below says otherwise
		alu_op      = rv_ctrl_pkg::alu_add; // address / jalr target adds
		alu_src_imm = 1'b0;
		wb_sel      = rv_ctrl_pkg::wb_alu;
		reg_write_d = 1'b0;
		mem_write_d = 1'b0;
		branch      = 1'b0;
		pc_kind     = rv_ctrl_pkg::pc_plus4;
		case (opcode)
			rv_isa_pkg::opc_op: begin
				alu_op      = arith_op;
				reg_write_d = 1'b1;
			end
			rv_isa_pkg::opc_op_imm: begin
				alu_op      = arith_op;
				alu_src_imm = 1'b1;
				reg_write_d = 1'b1;
			end
			rv_isa_pkg::opc_load: begin
				alu_src_imm = 1'b1;
				wb_sel      = rv_ctrl_pkg::wb_load;
				reg_write_d = 1'b1;
			end
			rv_isa_pkg::opc_store: begin
				alu_src_imm = 1'b1; // s-type imm picked in datapath
				mem_write_d = 1'b1;
			end
			rv_isa_pkg::opc_branch: begin
				branch  = 1'b1; // rs1 vs rs2, no imm on the alu
				pc_kind = rv_ctrl_pkg::pc_branch;
			end
			rv_isa_pkg::opc_jal: begin
				wb_sel      = rv_ctrl_pkg::wb_pc_plus4;
				reg_write_d = 1'b1;
				pc_kind     = rv_ctrl_pkg::pc_jal;
			end
			rv_isa_pkg::opc_jalr: begin
				alu_src_imm = 1'b1;
				wb_sel      = rv_ctrl_pkg::wb_pc_plus4;
				reg_write_d = 1'b1;
				pc_kind     = rv_ctrl_pkg::pc_jalr;
			end
			rv_isa_pkg::opc_lui: begin
				wb_sel      = rv_ctrl_pkg::wb_upper_imm;
				reg_write_d = 1'b1;
			end
			rv_isa_pkg::opc_auipc: begin
				wb_sel      = rv_ctrl_pkg::wb_pc_plus_upper;
				reg_write_d = 1'b1;
			end
			default: ; // misc, system, illegal
		endcase
	end

	// branch falls through unless the comparator says taken
	assign pc_sel = (branch && !br_taken) ? rv_ctrl_pkg::pc_plus4 : pc_kind;

	assign reg_write = reset & reg_write_d; // reset active low
	assign mem_write = reset & mem_write_d;

endmodule : controller

// ==== src/datapath.sv ====
/* single-cycle RV32I datapath with pc, regfile, alu and branch compare
   loads and stores must be naturally aligned, dmem_rdata is used in the same cycle */
`include "rv_config.svh"

module datapath (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [31:0]                      instr,
	input  rv_ctrl_pkg::alu_op_e             alu_op,
	input  logic                             alu_src_imm,
	input  rv_ctrl_pkg::wb_sel_e             wb_sel,
	input  logic                             reg_write,
	input  logic                             mem_write,
	input  rv_ctrl_pkg::pc_sel_e             pc_sel,
	output logic                             br_taken,
	output logic [`RV_XLEN-1:0]              pc,
	output logic [`RV_XLEN-1:0]              dmem_addr,
	output logic [`RV_XLEN-1:0]              dmem_wdata,
	output logic [3:0]                       dmem_wmask,
	output logic                             dmem_we,
	input  logic [`RV_XLEN-1:0]              dmem_rdata,
	output logic                             rd_we,
	output logic [$clog2(`RV_NREGS)-1:0]     rd_addr,
	output logic [`RV_XLEN-1:0]              rd_data
);
	rv_isa_pkg::opcode_e         opcode;
	rv_isa_pkg::funct3_e         mem_f3;
	logic [$clog2(`RV_NREGS)-1:0] rs1, rs2;
	logic [`RV_XLEN-1:0]         imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [`RV_XLEN-1:0]         rs1_data, rs2_data, src_b, alu_y;
	logic [`RV_XLEN-1:0]         pc_inc, pc_next, ld_word, ld_val;
	logic [1:0]                  byte_off;
	logic [4:0]                  lane_sh; // byte offset in bits

	assign opcode  = rv_isa_pkg::opcode_e'(instr[6:0]);
	assign mem_f3  = rv_isa_pkg::funct3_e'(instr[14:12]);
	assign rd_addr = instr[11:7];
	assign rs1     = instr[19:15];
	assign rs2     = instr[24:20];

	// immediates, all sign-extended from instr[31]
	assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0}; // lui / auipc
	assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
		instr[30:21], 1'b0};

	assign rd_we = reg_write && (rd_addr != '0); // x0 writes dropped here

	reg_file rf0 (
		.clk(clk), .we(rd_we), .rs1(rs1), .rs2(rs2), .rd(rd_addr), .wd(rd_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	// stores use s-type, everything else with an imm uses i-type
	assign src_b = !alu_src_imm ? rs2_data :
		(opcode == rv_isa_pkg::opc_store) ? imm_s : imm_i;

	// alu and comparator share rs1 / src_b
	alu alu0 (.a(rs1_data), .b(src_b), .op(alu_op), .y(alu_y));
	branch_cmp bcmp0 (
		.a(rs1_data), .b(src_b), .funct3(rv_isa_pkg::br_funct_e'(instr[14:12])),
		.taken(br_taken)
	);

	assign dmem_addr = alu_y;
	assign dmem_we   = mem_write;
	assign byte_off  = alu_y[1:0];
	assign lane_sh   = {byte_off, 3'b000};

	// store lanes, mask stays a legal pattern even off stores
	always_comb begin
		case (mem_f3)
			rv_isa_pkg::f3_byte, rv_isa_pkg::f3_byte_u: begin
				dmem_wmask = 4'b0001 << byte_off;
				dmem_wdata = {{(`RV_XLEN-8){1'b0}}, rs2_data[7:0]} << lane_sh;
			end
			rv_isa_pkg::f3_half, rv_isa_pkg::f3_half_u: begin
				dmem_wmask = byte_off[1] ? 4'b1100 : 4'b0011;
				dmem_wdata = {{(`RV_XLEN-16){1'b0}}, rs2_data[15:0]} << {byte_off[1], 4'b0000};
			end
			default: begin
				dmem_wmask = 4'b1111;
				dmem_wdata = rs2_data;
			end
		endcase
	end

	// load lane to bit 0, then extend
	assign ld_word = dmem_rdata >> lane_sh;
	always_comb begin
		case (mem_f3)
			rv_isa_pkg::f3_byte:   ld_val = {{(`RV_XLEN-8){ld_word[7]}}, ld_word[7:0]};
			rv_isa_pkg::f3_half:   ld_val = {{(`RV_XLEN-16){ld_word[15]}}, ld_word[15:0]};
			rv_isa_pkg::f3_byte_u: ld_val = {{(`RV_XLEN-8){1'b0}}, ld_word[7:0]};
			rv_isa_pkg::f3_half_u: ld_val = {{(`RV_XLEN-16){1'b0}}, ld_word[15:0]};
			default:               ld_val = dmem_rdata; // lw
		endcase
	end

	assign pc_inc = pc + `RV_XLEN'd4;

	always_comb begin
		case (wb_sel)
			rv_ctrl_pkg::wb_load:          rd_data = ld_val;
			rv_ctrl_pkg::wb_pc_plus4:      rd_data = pc_inc; // link
			rv_ctrl_pkg::wb_upper_imm:     rd_data = imm_u;
			rv_ctrl_pkg::wb_pc_plus_upper: rd_data = pc + imm_u;
			default:                       rd_data = alu_y;
		endcase
	end

	always_comb begin
		case (pc_sel)
			rv_ctrl_pkg::pc_branch: pc_next = pc + imm_b;
			rv_ctrl_pkg::pc_jal:    pc_next = pc + imm_j;
			rv_ctrl_pkg::pc_jalr:   pc_next = {alu_y[`RV_XLEN-1:1], 1'b0}; // bit 0 cleared
			default:                pc_next = pc_inc;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			pc <= `RV_RESET_PC;
		else
			pc <= pc_next;
	end

endmodule : datapath

// 2 read / 1 write, x0 reads as zero
module reg_file (
	input  logic                         clk,
	input  logic                         we,
	input  logic [$clog2(`RV_NREGS)-1:0] rs1, rs2, rd,
	input  logic [`RV_XLEN-1:0]          wd,
	output logic [`RV_XLEN-1:0]          rs1_data, rs2_data
);
	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	always_ff @(posedge clk) begin
		if (we)
			regs[rd] <= wd;
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule : reg_file

// ==== src/rv_core.sv ====
/* single-cycle RV32I core top, one instruction retired per clk
   imem and dmem must answer combinationally, no stall path */
`include "rv_config.svh"

module rv_core (
	input  logic                         clk,
	input  logic                         reset,
	// instruction port
	output logic [`RV_XLEN-1:0]          pc,
	input  logic [31:0]                  instr,
	// data memory port
	output logic [`RV_XLEN-1:0]          dmem_addr,
	output logic [`RV_XLEN-1:0]          dmem_wdata,
	output logic [3:0]                   dmem_wmask,
	output logic                         dmem_we,
	input  logic [`RV_XLEN-1:0]          dmem_rdata,
	// writeback of the current instruction
	output logic                         rd_we,
	output logic [$clog2(`RV_NREGS)-1:0] rd_addr,
	output logic [`RV_XLEN-1:0]          rd_data
);
	rv_ctrl_pkg::alu_op_e alu_op;
	rv_ctrl_pkg::wb_sel_e wb_sel;
	rv_ctrl_pkg::pc_sel_e pc_sel;
	logic                 alu_src_imm;
	logic                 reg_write, mem_write;
	logic                 br_taken; // raw compare, resolved in controller

	controller ctrl0 (
		.reset(reset), .instr(instr), .br_taken(br_taken),
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .wb_sel(wb_sel),
		.reg_write(reg_write), .mem_write(mem_write), .pc_sel(pc_sel)
	);

	datapath dp0 (
		.clk(clk), .reset(reset), .instr(instr),
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .wb_sel(wb_sel),
		.reg_write(reg_write), .mem_write(mem_write), .pc_sel(pc_sel),
		.br_taken(br_taken), .pc(pc),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
		.dmem_we(dmem_we), .dmem_rdata(dmem_rdata),
		.rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data)
	);

endmodule : rv_core

// ==== src/rv_ctrl_pkg.sv ====
/* internal control encodings between controller and datapath
   values are private to the core and may be reordered freely */
package rv_ctrl_pkg;

	// alu operation
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	// writeback source for rd
	typedef enum logic [2:0] {
		wb_alu,
		wb_load,
		wb_pc_plus4,      // jal / jalr link
		wb_upper_imm,     // lui
		wb_pc_plus_upper  // auipc
	} wb_sel_e;

	// next pc source
	typedef enum logic [1:0] {
		pc_plus4, pc_branch, pc_jal, pc_jalr
	} pc_sel_e;

endpackage : rv_ctrl_pkg

// ==== src/rv_isa_pkg.sv ====
/* RV32I instruction encoding fields
   only the base integer opcodes are listed, the rest decode as no-ops */
package rv_isa_pkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011, // reg-reg alu
		opc_op_imm = 7'b0010011, // reg-imm alu
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_misc   = 7'b0001111  // fence, treated as no-op
	} opcode_e;

	// load / store width in funct3
	typedef enum logic [2:0] {
		f3_byte   = 3'b000,
		f3_half   = 3'b001,
		f3_word   = 3'b010,
		f3_byte_u = 3'b100, // loads only
		f3_half_u = 3'b101  // loads only
	} funct3_e;

	// branch condition in funct3
	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} br_funct_e;

endpackage : rv_isa_pkg

// ==== tb/core_asserts.sv ====
/* concurrent checks on the core's control outputs, bound into rv_core
   mask legality is only checked on cycles that store */
module core_asserts (
	input logic        clk,
	input logic        reset,
	input logic        dmem_we,
	input logic        rd_we,
	input logic [31:0] pc,
	input logic [3:0]  dmem_wmask,
	input logic [4:0]  rd_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	no_write_in_reset: assert property (@(posedge clk) !reset |-> !dmem_we && !rd_we)
		else $error("store or register write while reset is low");

	// byte, half or word lanes only
	legal_mask: assert property (@(posedge clk) disable iff (!reset)
		dmem_we |-> dmem_wmask inside {4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
		else $error("illegal store byte mask %b", dmem_wmask);

	no_x0_write: assert property (@(posedge clk) rd_we |-> rd_addr != 5'd0)
		else $error("register write aimed at x0");

	pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

endmodule : core_asserts

bind rv_core core_asserts asrt0 (
	.clk(clk), .reset(reset), .dmem_we(dmem_we), .rd_we(rd_we), .pc(pc),
	.dmem_wmask(dmem_wmask), .rd_addr(rd_addr)
);

// ==== tb/core_checker.sv ====
/* compares store traffic in order and final registers against the stim records
   store data is compared only in the byte lanes its mask enables */
module core_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        done,
	input  logic        dmem_we,
	input  logic        rd_we,
	input  logic [31:0] dmem_addr,
	input  logic [31:0] dmem_wdata,
	input  logic [3:0]  dmem_wmask,
	input  logic [4:0]  rd_addr,
	input  logic [31:0] rd_data,
	input  logic [31:0] exp_addr [64],
	input  logic [31:0] exp_data [64],
	input  logic [3:0]  exp_mask [64],
	input  logic [31:0] exp_reg [32],
	input  logic [31:0] reg_chk,
	input  int          n_exp,
	output int          st_seen,
	output int          err_count
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] shadow [32]; // mirrors rd writebacks

	function automatic logic [31:0] lane_bits(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp, got);
		if (exp !== got) begin
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
			err_count++;
		end
	endtask

	initial begin
		st_seen = 0;
		err_count = 0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
	end

	// outputs of the retiring instruction, sampled at its commit edge
	always @(posedge clk) begin
		if (!reset && (dmem_we || rd_we)) begin
			$display("a store or register write happened while reset was low at %0t", $time);
			err_count++;
		end
		if (reset && dmem_we) begin
			if (st_seen >= n_exp) begin
				$display("an extra store to address %h happened at %0t", dmem_addr, $time);
				err_count++;
			end else begin
				compare_value("dmem_addr", exp_addr[st_seen], dmem_addr);
				compare_value("dmem_wmask", {28'b0, exp_mask[st_seen]}, {28'b0, dmem_wmask});
				compare_value("dmem_wdata", exp_data[st_seen] & lane_bits(exp_mask[st_seen]),
					dmem_wdata & lane_bits(exp_mask[st_seen]));
			end
			st_seen++;
		end
		if (reset && rd_we)
			shadow[rd_addr] = rd_data;
	end

	always @(posedge done) begin
		for (int r = 1; r < 32; r++) begin
			if (reg_chk[r])
				compare_value($sformatf("x%0d", r), exp_reg[r], shadow[r]);
		end
	end

endmodule : core_checker

// ==== tb/core_stim.txt ====
# I <instr word> | S <addr> <data> <mask> expected store in order | R <reg> <value> final reg
# alu and immediates, lui
I FFB00093
I 00300113
I 402081B3
I 0020A233
I 0020B2B3
I 4010D313
I 123453B7
I 67838393
# sw, sb, sh then loads of the stored bytes
I 00702023
I 001002A3
I 00101523
I 00500403
I 00504483
I 00A01503
I 00A05583
I 00201603
# six conditions, taken then not taken, each followed by a marker store
I 00420463
I 04402023
I 00208463
I 04402223
I 00209463
I 04402423
I 00421463
I 04402623
I 0020C463
I 04402823
I 00114463
I 04402A23
I 00115463
I 04402C23
I 0020D463
I 04402E23
I 00116463
I 06402023
I 0020E463
I 06402223
I 0020F463
I 06402423
I 00117463
I 06402623
# jal skips a store, auipc, jalr to odd target, link stored, self jump
I 008006EF
I 06402823
I 00000717
I 00D707E7
I 06402A23
I 06F02C23
I 0000006F
S 00000000 12345678 F
S 00000005 0000FB00 2
S 0000000A FFFB0000 C
S 00000044 00000001 F
S 0000004C 00000001 F
S 00000054 00000001 F
S 0000005C 00000001 F
S 00000064 00000001 F
S 0000006C 00000001 F
S 00000078 000000B0 F
R 01 FFFFFFFB
R 02 00000003
R 03 FFFFFFF8
R 04 00000001
R 05 00000000
R 06 FFFFFFFD
R 07 12345678
R 08 FFFFFFFB
R 09 000000FB
R 0A FFFFFFFB
R 0B 0000FFFB
R 0C 00001234
R 0D 000000A4
R 0E 000000A8
R 0F 000000B0

// ==== tb/tb_core.sv ====
/* testbench for rv_core, program and expected results come from tb/core_stim.txt
   imem and dmem hold 256 words each, so addresses wrap above 1 KiB */
`include "rv_config.svh"

module tb_core;
	timeunit 1ns;
	timeprecision 100ps;

	logic                         clk, reset, done, loaded;
	logic [`RV_XLEN-1:0]          pc, dmem_addr, dmem_wdata, dmem_rdata, rd_data;
	logic [31:0]                  instr;
	logic [3:0]                   dmem_wmask;
	logic                         dmem_we, rd_we;
	logic [$clog2(`RV_NREGS)-1:0] rd_addr;
	logic [31:0]                  imem [256];
	logic [31:0]                  dmem [256];
	logic [31:0]                  exp_addr [64]; // expected stores, in order
	logic [31:0]                  exp_data [64];
	logic [3:0]                   exp_mask [64];
	logic [31:0]                  exp_reg [32];  // expected final registers
	logic [31:0]                  reg_chk;       // which registers have an R record
	int                           n_exp, n_words, st_seen, chk_errs, tb_errs, seed, limit;

	assign instr      = imem[pc[9:2]];        // combinational fetch
	assign dmem_rdata = dmem[dmem_addr[9:2]]; // combinational load

	always #2 clk = ~clk;

	// byte lanes written on the rising edge
	always @(posedge clk) begin
		if (dmem_we) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_wmask[b])
					dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
			end
		end
	end

	rv_core dut0 (.*);

	core_checker chk0 (.*, .err_count(chk_errs));

	// I word, S addr data mask, R reg value
	task automatic load_stim();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] a, b, c;
		fd = $fopen("tb/core_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/core_stim.txt");
			tb_errs++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			if (line.len() < 3 || line.getc(0) == "#")
				continue;
			a = '0;
			b = '0;
			c = '0;
			cnt = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c);
			if (line.getc(0) == "I") begin
				imem[n_words] = a;
				n_words++;
			end else if (line.getc(0) == "S") begin
				exp_addr[n_exp] = a;
				exp_data[n_exp] = b;
				exp_mask[n_exp] = c[3:0];
				n_exp++;
			end else if (line.getc(0) == "R") begin
				exp_reg[a[4:0]] = b;
				reg_chk[a[4:0]] = 1'b1;
			end
		end
		$fclose(fd);
	endtask

	// program parks in a self jump, pc stops moving
	task automatic wait_for_end();
		logic [31:0] last_pc;
		int          same;
		last_pc = pc;
		same = 0;
		while (!(same >= 4 && st_seen >= n_exp)) begin
			@(negedge clk);
			if (pc == last_pc)
				same++;
			else
				same = 0;
			last_pc = pc;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		done = 1'b0;
		loaded = 1'b0;
		seed = 55;
		n_exp = 0;
		n_words = 0;
		tb_errs = 0;
		reg_chk = '0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;             // opcode 0 decodes as a no-op
			dmem[i] = $random(seed);  // background the program never relies on
		end
		for (int i = 0; i < 32; i++)
			exp_reg[i] = '0;
		load_stim();
		limit = 20 * n_words + 200;
		loaded = 1'b1;
		repeat (16) @(negedge clk);
		if (pc !== `RV_RESET_PC) begin
			$display("Error at %0t: pc expected %h got %h", $time, `RV_RESET_PC, pc);
			tb_errs++;
		end
		reset = 1'b1; // released on a falling edge
		wait_for_end();
		done = 1'b1;
		#1;
		$display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
		if (chk_errs + tb_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog, scaled to program length
	initial begin
		wait (loaded);
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, the program never reached its final loop", limit);
		tb_errs++;
		$display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
		$display("*** FAILED ***");
		$finish;
	end

endmodule : tb_core
